//--- logic/id_pkg.sv
package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // op_nop must stay at zero, the pipeline register clears to it
    typedef enum logic [7:0] {
        op_nop,
        op_and, op_or, op_xor, op_nor,
        op_sll, op_srl, op_sra,
        op_slt, op_sltu, op_add, op_addu, op_sub, op_subu,
        op_j, op_jal, op_jr, op_jalr,
        op_beq, op_bne, op_bgtz, op_blez,
        op_bgez, op_bltz, op_bgezal, op_bltzal
    } operator_t;

    typedef enum logic [2:0] {
        cat_none,
        cat_logic,
        cat_shift,
        cat_arithmetic,
        cat_jump
    } category_t;

    // nine kinds, so one bit wider than the category
    typedef enum logic [3:0] {
        br_none,
        br_always_imm26,
        br_always_reg,
        br_eq,
        br_ne,
        br_gtz,
        br_lez,
        br_gez,
        br_ltz
    } branch_kind_t;

    // primary opcodes
    localparam logic [5:0] opc_special = 6'h00;
    localparam logic [5:0] opc_regimm  = 6'h01;
    localparam logic [5:0] opc_j       = 6'h02;
    localparam logic [5:0] opc_jal     = 6'h03;
    localparam logic [5:0] opc_beq     = 6'h04;
    localparam logic [5:0] opc_bne     = 6'h05;
    localparam logic [5:0] opc_blez    = 6'h06;
    localparam logic [5:0] opc_bgtz    = 6'h07;
    localparam logic [5:0] opc_addi    = 6'h08;
    localparam logic [5:0] opc_addiu   = 6'h09;
    localparam logic [5:0] opc_slti    = 6'h0a;
    localparam logic [5:0] opc_sltiu   = 6'h0b;
    localparam logic [5:0] opc_andi    = 6'h0c;
    localparam logic [5:0] opc_ori     = 6'h0d;
    localparam logic [5:0] opc_xori    = 6'h0e;
    localparam logic [5:0] opc_lui     = 6'h0f;

    // SPECIAL function field
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_jalr = 6'h09;
    localparam logic [5:0] fn_add  = 6'h20;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_sub  = 6'h22;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // REGIMM rt field
    localparam logic [4:0] rt_bltz   = 5'h00;
    localparam logic [4:0] rt_bgez   = 5'h01;
    localparam logic [4:0] rt_bltzal = 5'h10;
    localparam logic [4:0] rt_bgezal = 5'h11;

    localparam reg_addr_t link_reg = 5'd31;
    localparam word_t     pc_step  = 32'd4;

endpackage

//--- logic/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder (
    input  id_pkg::word_t        instruction,
    output logic                 rd_en_a,
    output logic                 rd_en_b,
    output id_pkg::reg_addr_t    rd_addr_a,
    output id_pkg::reg_addr_t    rd_addr_b,
    output id_pkg::word_t        immediate,
    output id_pkg::operator_t    operator,
    output id_pkg::category_t    category,
    output logic                 wr_en,
    output id_pkg::reg_addr_t    wr_addr,
    output logic                 link_en,
    output id_pkg::branch_kind_t branch_kind
);
    import id_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  sa;
    logic [15:0] imm16;

    // register forms, the variable shifts share the shift operators
    function automatic operator_t special_op(input logic [5:0] code);
        case (code)
            fn_and:           return op_and;
            fn_or:            return op_or;
            fn_xor:           return op_xor;
            fn_nor:           return op_nor;
            fn_sll, fn_sllv:  return op_sll;
            fn_srl, fn_srlv:  return op_srl;
            fn_sra, fn_srav:  return op_sra;
            fn_slt:           return op_slt;
            fn_sltu:          return op_sltu;
            fn_add:           return op_add;
            fn_addu:          return op_addu;
            fn_sub:           return op_sub;
            fn_subu:          return op_subu;
            default:          return op_nop;
        endcase
    endfunction

    function automatic operator_t imm_op(input logic [5:0] code);
        case (code)
            opc_andi:          return op_and;
            opc_ori, opc_lui:  return op_or;
            opc_xori:          return op_xor;
            opc_slti:          return op_slt;
            opc_sltiu:         return op_sltu;
            opc_addi:          return op_add;
            opc_addiu:         return op_addu;
            default:           return op_nop;
        endcase
    endfunction

    function automatic category_t category_of(input operator_t op);
        case (op)
            op_nop:                          return cat_none;
            op_and, op_or, op_xor, op_nor:   return cat_logic;
            op_sll, op_srl, op_sra:          return cat_shift;
            op_slt, op_sltu, op_add, op_addu,
            op_sub, op_subu:                 return cat_arithmetic;
            default:                         return cat_jump;
        endcase
    endfunction

    assign opcode = instruction[31:26];
    assign rs     = instruction[25:21];
    assign rt     = instruction[20:16];
    assign rd     = instruction[15:11];
    assign sa     = instruction[10:6];
    assign funct  = instruction[5:0];
    assign imm16  = instruction[15:0];

    // port a reads rs, port b reads rt
    assign rd_addr_a = rs;
    assign rd_addr_b = rt;
    assign category  = category_of(operator);

    always_comb begin
        rd_en_a     = 1'b0;
        rd_en_b     = 1'b0;
        immediate   = '0;
        operator    = op_nop;
        wr_en       = 1'b0;
        wr_addr     = rd;
        link_en     = 1'b0;
        branch_kind = br_none;

        case (opcode)
            opc_special: begin
                case (funct)
                    fn_sll, fn_srl, fn_sra: begin
                        // shift amount rides on port a
                        if (rs == 5'd0) begin
                            rd_en_b   = 1'b1;
                            immediate = {27'd0, sa};
                            operator  = special_op(funct);
                            wr_en     = 1'b1;
                        end
                    end
                    fn_jr, fn_jalr: begin
                        if (sa == 5'd0) begin
                            rd_en_a     = 1'b1;
                            operator    = (funct == fn_jr) ? op_jr : op_jalr;
                            branch_kind = br_always_reg;
                            wr_en       = (funct == fn_jalr);
                            link_en     = (funct == fn_jalr);
                        end
                    end
                    default: begin
                        if (sa == 5'd0 && special_op(funct) != op_nop) begin
                            rd_en_a  = 1'b1;
                            rd_en_b  = 1'b1;
                            operator = special_op(funct);
                            wr_en    = 1'b1;
                        end
                    end
                endcase
            end
            opc_regimm: begin
                if (rt inside {rt_bgez, rt_bltz, rt_bgezal, rt_bltzal}) begin
                    rd_en_a     = 1'b1;
                    branch_kind = (rt[0]) ? br_gez : br_ltz;
                    // bit 4 of rt marks the linking forms
                    wr_en       = rt[4];
                    link_en     = rt[4];
                    wr_addr     = link_reg;
                    case (rt)
                        rt_bgez:   operator = op_bgez;
                        rt_bltz:   operator = op_bltz;
                        rt_bgezal: operator = op_bgezal;
                        default:   operator = op_bltzal;
                    endcase
                end
            end
            opc_andi, opc_ori, opc_xori, opc_lui,
            opc_slti, opc_sltiu, opc_addi, opc_addiu: begin
                rd_en_a  = 1'b1;
                operator = imm_op(opcode);
                wr_en    = 1'b1;
                wr_addr  = rt;
                if (opcode == opc_lui) begin
                    immediate = {imm16, 16'd0};
                end else if (opcode inside {opc_andi, opc_ori, opc_xori}) begin
                    immediate = {16'd0, imm16};
                end else begin
                    immediate = {{16{imm16[15]}}, imm16};
                end
            end
            opc_j, opc_jal: begin
                operator    = (opcode == opc_j) ? op_j : op_jal;
                branch_kind = br_always_imm26;
                wr_en       = (opcode == opc_jal);
                link_en     = (opcode == opc_jal);
                wr_addr     = link_reg;
            end
            opc_beq, opc_bne: begin
                rd_en_a     = 1'b1;
                rd_en_b     = 1'b1;
                operator    = (opcode == opc_beq) ? op_beq : op_bne;
                branch_kind = (opcode == opc_beq) ? br_eq : br_ne;
            end
            opc_bgtz, opc_blez: begin
                rd_en_a     = 1'b1;
                operator    = (opcode == opc_bgtz) ? op_bgtz : op_blez;
                branch_kind = (opcode == opc_bgtz) ? br_gtz : br_lez;
            end
            default: begin
                operator = op_nop;
            end
        endcase
    end

endmodule

//--- logic/operand_select.sv
`timescale 1ns/1ps

module operand_select (
    input  logic              rd_en,
    input  id_pkg::reg_addr_t rd_addr,
    input  id_pkg::word_t     rdata,
    input  id_pkg::word_t     immediate,
    input  logic              ex_wr_en,
    input  id_pkg::reg_addr_t ex_wr_addr,
    input  id_pkg::word_t     ex_wr_data,
    input  logic              mem_wr_en,
    input  id_pkg::reg_addr_t mem_wr_addr,
    input  id_pkg::word_t     mem_wr_data,
    output id_pkg::word_t     operand
);
    import id_pkg::*;

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_wr_en && (ex_wr_addr == rd_addr);
    assign mem_hit = mem_wr_en && (mem_wr_addr == rd_addr);

    // ex is the younger result, so it wins over mem
    always_comb begin
        if (!rd_en) begin
            operand = immediate;
        end else if (ex_hit) begin
            operand = ex_wr_data;
        end else if (mem_hit) begin
            operand = mem_wr_data;
        end else begin
            operand = rdata;
        end
    end

endmodule

//--- logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  id_pkg::branch_kind_t branch_kind,
    input  id_pkg::word_t        pc,
    input  id_pkg::word_t        instruction,
    input  id_pkg::word_t        operand_a,
    input  id_pkg::word_t        operand_b,
    output logic                 pc_wr_en,
    output id_pkg::word_t        pc_wr_data,
    output id_pkg::word_t        link_addr
);
    import id_pkg::*;

    word_t pc_next;
    word_t branch_target;
    word_t jump_target;

    assign pc_next   = pc + pc_step;
    // return past the delay slot
    assign link_addr = pc_next + pc_step;

    assign branch_target = pc_next + {{14{instruction[15]}}, instruction[15:0], 2'b00};
    assign jump_target   = {pc_next[31:28], instruction[25:0], 2'b00};

    always_comb begin
        pc_wr_en   = 1'b0;
        pc_wr_data = branch_target;
        case (branch_kind)
            br_always_imm26: begin
                pc_wr_en   = 1'b1;
                pc_wr_data = jump_target;
            end
            br_always_reg: begin
                pc_wr_en   = 1'b1;
                pc_wr_data = operand_a;
            end
            br_eq:  pc_wr_en = (operand_a == operand_b);
            br_ne:  pc_wr_en = (operand_a != operand_b);
            br_gtz: pc_wr_en = ($signed(operand_a) > 32'sd0);
            br_lez: pc_wr_en = ($signed(operand_a) <= 32'sd0);
            br_gez: pc_wr_en = !operand_a[31];
            br_ltz: pc_wr_en = operand_a[31];
            default: begin
                pc_wr_data = '0;
            end
        endcase
    end

endmodule

//--- logic/id_ex_register.sv
`timescale 1ns/1ps

module id_ex_register (
    input  logic               clk,
    input  logic               arst_n,
    input  id_pkg::operator_t  d_operator,
    input  id_pkg::category_t  d_category,
    input  id_pkg::word_t      d_operand_a,
    input  id_pkg::word_t      d_operand_b,
    input  logic               d_wr_en,
    input  id_pkg::reg_addr_t  d_wr_addr,
    input  id_pkg::word_t      d_wr_data,
    output id_pkg::operator_t  operator,
    output id_pkg::category_t  category,
    output id_pkg::word_t      operand_a,
    output id_pkg::word_t      operand_b,
    output logic               wr_en,
    output id_pkg::reg_addr_t  wr_addr,
    output id_pkg::word_t      wr_data
);
    import id_pkg::*;

    // a cleared stage looks like a nop to ex
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            operator  <= op_nop;
            category  <= cat_none;
            operand_a <= '0;
            operand_b <= '0;
            wr_en     <= 1'b0;
            wr_addr   <= '0;
            wr_data   <= '0;
        end else begin
            operator  <= d_operator;
            category  <= d_category;
            operand_a <= d_operand_a;
            operand_b <= d_operand_b;
            wr_en     <= d_wr_en;
            wr_addr   <= d_wr_addr;
            wr_data   <= d_wr_data;
        end
    end

endmodule

//--- logic/stage_id.sv
`timescale 1ns/1ps

module stage_id (
    input  logic              clk,
    input  logic              arst_n,
    input  id_pkg::word_t     instruction,
    input  id_pkg::word_t     pc,
    output logic              reg_rd_en_a,
    output id_pkg::reg_addr_t reg_rd_addr_a,
    input  id_pkg::word_t     reg_rdata_a,
    output logic              reg_rd_en_b,
    output id_pkg::reg_addr_t reg_rd_addr_b,
    input  id_pkg::word_t     reg_rdata_b,
    input  logic              ex_wr_en,
    input  id_pkg::reg_addr_t ex_wr_addr,
    input  id_pkg::word_t     ex_wr_data,
    input  logic              mem_wr_en,
    input  id_pkg::reg_addr_t mem_wr_addr,
    input  id_pkg::word_t     mem_wr_data,
    output logic              pc_wr_en,
    output id_pkg::word_t     pc_wr_data,
    output id_pkg::operator_t operator,
    output id_pkg::category_t category,
    output id_pkg::word_t     operand_a,
    output id_pkg::word_t     operand_b,
    output logic              wr_en,
    output id_pkg::reg_addr_t wr_addr,
    output id_pkg::word_t     wr_data
);
    import id_pkg::*;

    word_t        immediate;
    operator_t    dec_operator;
    category_t    dec_category;
    logic         dec_wr_en;
    reg_addr_t    dec_wr_addr;
    logic         link_en;
    branch_kind_t branch_kind;
    word_t        sel_operand_a;
    word_t        sel_operand_b;
    word_t        link_addr;
    word_t        dec_wr_data;

    instruction_decoder u_decoder (
        .instruction (instruction),
        .rd_en_a     (reg_rd_en_a),
        .rd_en_b     (reg_rd_en_b),
        .rd_addr_a   (reg_rd_addr_a),
        .rd_addr_b   (reg_rd_addr_b),
        .immediate   (immediate),
        .operator    (dec_operator),
        .category    (dec_category),
        .wr_en       (dec_wr_en),
        .wr_addr     (dec_wr_addr),
        .link_en     (link_en),
        .branch_kind (branch_kind)
    );

    operand_select u_operand_a (
        .rd_en       (reg_rd_en_a),
        .rd_addr     (reg_rd_addr_a),
        .rdata       (reg_rdata_a),
        .immediate   (immediate),
        .ex_wr_en    (ex_wr_en),
        .ex_wr_addr  (ex_wr_addr),
        .ex_wr_data  (ex_wr_data),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .operand     (sel_operand_a)
    );

    operand_select u_operand_b (
        .rd_en       (reg_rd_en_b),
        .rd_addr     (reg_rd_addr_b),
        .rdata       (reg_rdata_b),
        .immediate   (immediate),
        .ex_wr_en    (ex_wr_en),
        .ex_wr_addr  (ex_wr_addr),
        .ex_wr_data  (ex_wr_data),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .operand     (sel_operand_b)
    );

    // branches compare the forwarded operands
    branch_unit u_branch (
        .branch_kind (branch_kind),
        .pc          (pc),
        .instruction (instruction),
        .operand_a   (sel_operand_a),
        .operand_b   (sel_operand_b),
        .pc_wr_en    (pc_wr_en),
        .pc_wr_data  (pc_wr_data),
        .link_addr   (link_addr)
    );

    // only the linking jumps and branches carry write data
    assign dec_wr_data = link_en ? link_addr : '0;

    id_ex_register u_id_ex (
        .clk         (clk),
        .arst_n      (arst_n),
        .d_operator  (dec_operator),
        .d_category  (dec_category),
        .d_operand_a (sel_operand_a),
        .d_operand_b (sel_operand_b),
        .d_wr_en     (dec_wr_en),
        .d_wr_addr   (dec_wr_addr),
        .d_wr_data   (dec_wr_data),
        .operator    (operator),
        .category    (category),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

endmodule

//--- bench/stage_id_vectors.svh
localparam int num_vectors = 23;

// columns: instruction, pc, ex forward (en, addr, data), mem forward (en, addr, data),
// then read enables {a, b}, pc_wr_en, pc_wr_data, operator, category, operand_a, operand_b,
// wr_en, wr_addr, wr_data
vector_t vectors [num_vectors] = '{
    // register forms, no forwarding
    '{32'h00a32024, 32'h00001000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b11,
      1'b0, 32'h0, op_and, cat_logic, 32'h05050505, 32'h03030303, 1'b1, 5'd4, 32'h0},
    '{32'h00223827, 32'h00001000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b11,
      1'b0, 32'h0, op_nor, cat_logic, 32'h01010101, 32'h02020202, 1'b1, 5'd7, 32'h0},
    '{32'h00c95023, 32'h00001000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b11,
      1'b0, 32'h0, op_subu, cat_arithmetic, 32'h06060606, 32'h09090909, 1'b1, 5'd10, 32'h0},
    '{32'h010b602a, 32'h00001000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b11,
      1'b0, 32'h0, op_slt, cat_arithmetic, 32'h08080808, 32'h0b0b0b0b, 1'b1, 5'd12, 32'h0},
    '{32'h004e6804, 32'h00001000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b11,
      1'b0, 32'h0, op_sll, cat_shift, 32'h02020202, 32'h0e0e0e0e, 1'b1, 5'd13, 32'h0},
    // immediates: zero extend, upper half, sign extend, shift amount
    '{32'h34658001, 32'h00001000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b10,
      1'b0, 32'h0, op_or, cat_logic, 32'h03030303, 32'h00008001, 1'b1, 5'd5, 32'h0},
    '{32'h3c081234, 32'h00001000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b10,
      1'b0, 32'h0, op_or, cat_logic, 32'h0, 32'h12340000, 1'b1, 5'd8, 32'h0},
    '{32'h2089fff0, 32'h00001000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b10,
      1'b0, 32'h0, op_add, cat_arithmetic, 32'h04040404, 32'hfffffff0, 1'b1, 5'd9, 32'h0},
    '{32'h000659c3, 32'h00001000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b01,
      1'b0, 32'h0, op_sra, cat_shift, 32'h00000007, 32'h06060606, 1'b1, 5'd11, 32'h0},
    // forwarding priority
    '{32'h00a61821, 32'h00001000, 1'b1, 5'd5, 32'haaaa0001, 1'b1, 5'd5, 32'hbbbb0002, 2'b11,
      1'b0, 32'h0, op_addu, cat_arithmetic, 32'haaaa0001, 32'h06060606, 1'b1, 5'd3, 32'h0},
    '{32'h00a61821, 32'h00001000, 1'b1, 5'd9, 32'haaaa0003, 1'b1, 5'd6, 32'hbbbb0004, 2'b11,
      1'b0, 32'h0, op_addu, cat_arithmetic, 32'h05050505, 32'hbbbb0004, 1'b1, 5'd3, 32'h0},
    // port b reads no register here, so the ex match on rt is ignored
    '{32'h34658001, 32'h00001000, 1'b1, 5'd5, 32'hcccc0005, 1'b1, 5'd3, 32'hdddd0006, 2'b10,
      1'b0, 32'h0, op_or, cat_logic, 32'hdddd0006, 32'h00008001, 1'b1, 5'd5, 32'h0},
    // jumps and branches
    '{32'h08000400, 32'h10000010, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b00,
      1'b1, 32'h10001000, op_j, cat_jump, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0},
    '{32'h00e00008, 32'h00002000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b10,
      1'b1, 32'h07070707, op_jr, cat_jump, 32'h07070707, 32'h0, 1'b0, 5'd0, 32'h0},
    '{32'h1042fffc, 32'h00002000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b11,
      1'b1, 32'h00001ff4, op_beq, cat_jump, 32'h02020202, 32'h02020202, 1'b0, 5'd0, 32'h0},
    '{32'h10430010, 32'h00002000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b11,
      1'b0, 32'h0, op_beq, cat_jump, 32'h02020202, 32'h03030303, 1'b0, 5'd0, 32'h0},
    '{32'h1c000008, 32'h00002000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b10,
      1'b0, 32'h0, op_bgtz, cat_jump, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0},
    '{32'h04800020, 32'h00003000, 1'b0, 5'd0, 32'h0, 1'b1, 5'd4, 32'h80000010, 2'b10,
      1'b1, 32'h00003084, op_bltz, cat_jump, 32'h80000010, 32'h0, 1'b0, 5'd0, 32'h0},
    // links return to pc plus 8
    '{32'h0c000800, 32'h00400000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b00,
      1'b1, 32'h00002000, op_jal, cat_jump, 32'h0, 32'h0, 1'b1, 5'd31, 32'h00400008},
    '{32'h0120c809, 32'h00400100, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b10,
      1'b1, 32'h09090909, op_jalr, cat_jump, 32'h09090909, 32'h0, 1'b1, 5'd25, 32'h00400108},
    '{32'h04d10004, 32'h00000500, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b10,
      1'b1, 32'h00000514, op_bgezal, cat_jump, 32'h06060606, 32'h0, 1'b1, 5'd31, 32'h00000508},
    // unknown opcode, then a dropped mfhi
    '{32'hfc001234, 32'h00001000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b00,
      1'b0, 32'h0, op_nop, cat_none, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0},
    '{32'h00001010, 32'h00001000, 1'b0, 5'd0, 32'h0, 1'b0, 5'd0, 32'h0, 2'b00,
      1'b0, 32'h0, op_nop, cat_none, 32'h0, 32'h0, 1'b0, 5'd0, 32'h0}
};

//--- bench/stage_id_tb.sv
`timescale 1ns/1ps

module stage_id_tb;
    import id_pkg::*;

    // one decode step: inputs first, expected results after
    typedef struct packed {
        word_t     instruction;
        word_t     pc;
        logic      ex_wr_en;
        reg_addr_t ex_wr_addr;
        word_t     ex_wr_data;
        logic      mem_wr_en;
        reg_addr_t mem_wr_addr;
        word_t     mem_wr_data;
        logic [1:0] rd_en;
        logic      pc_wr_en;
        word_t     pc_wr_data;
        operator_t operator;
        category_t category;
        word_t     operand_a;
        word_t     operand_b;
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     wr_data;
    } vector_t;

    // opcode 6'h3f is not decoded
    localparam word_t idle_instruction = 32'hfc00_0000;

    logic      clk;
    logic      arst_n;
    word_t     instruction;
    word_t     pc;
    logic      reg_rd_en_a;
    reg_addr_t reg_rd_addr_a;
    word_t     reg_rdata_a;
    logic      reg_rd_en_b;
    reg_addr_t reg_rd_addr_b;
    word_t     reg_rdata_b;
    logic      ex_wr_en;
    reg_addr_t ex_wr_addr;
    word_t     ex_wr_data;
    logic      mem_wr_en;
    reg_addr_t mem_wr_addr;
    word_t     mem_wr_data;
    logic      pc_wr_en;
    word_t     pc_wr_data;
    operator_t operator;
    category_t category;
    word_t     operand_a;
    word_t     operand_b;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    `include "stage_id_vectors.svh"

    // reset, one settling cycle and one cycle per vector, with margin
    localparam int cycle_limit = 2 * num_vectors + 20;

    int cycles = 0;
    int current = -1;

    stage_id dut (.*);

    always #2 clk = ~clk;

    // register n holds n times 32'h01010101
    assign reg_rdata_a = {27'd0, reg_rd_addr_a} * 32'h0101_0101;
    assign reg_rdata_b = {27'd0, reg_rd_addr_b} * 32'h0101_0101;

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the test did not finish within %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("** Error: vector %0d %s is 0x%h, expected 0x%h",
                     current, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t actual,
                                  input reg_addr_t expected);
        if (actual !== expected) begin
            $display("** Error: vector %0d %s is 0x%h, expected 0x%h",
                     current, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_operator(input string name, input operator_t actual,
                                  input operator_t expected);
        if (actual !== expected) begin
            $display("** Error: vector %0d %s is 0x%h, expected 0x%h",
                     current, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_category(input string name, input category_t actual,
                                  input category_t expected);
        if (actual !== expected) begin
            $display("** Error: vector %0d %s is 0x%h, expected 0x%h",
                     current, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error: vector %0d %s is 0x%h, expected 0x%h",
                     current, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_reset_state();
        check_operator("operator", operator, op_nop);
        check_category("category", category, cat_none);
        check_word("operand_a", operand_a, 32'h0);
        check_word("operand_b", operand_b, 32'h0);
        check_bit("wr_en", wr_en, 1'b0);
        check_reg_addr("wr_addr", wr_addr, 5'd0);
        check_word("wr_data", wr_data, 32'h0);
    endtask

    task automatic drive_vector(input vector_t v);
        instruction = v.instruction;
        pc          = v.pc;
        ex_wr_en    = v.ex_wr_en;
        ex_wr_addr  = v.ex_wr_addr;
        ex_wr_data  = v.ex_wr_data;
        mem_wr_en   = v.mem_wr_en;
        mem_wr_addr = v.mem_wr_addr;
        mem_wr_data = v.mem_wr_data;
    endtask

    // the redirect target only matters when the pc is written
    task automatic check_combinational(input vector_t v);
        check_bit("reg_rd_en_a", reg_rd_en_a, v.rd_en[1]);
        check_bit("reg_rd_en_b", reg_rd_en_b, v.rd_en[0]);
        check_bit("pc_wr_en", pc_wr_en, v.pc_wr_en);
        if (v.pc_wr_en) begin
            check_word("pc_wr_data", pc_wr_data, v.pc_wr_data);
        end
    endtask

    task automatic check_registered(input vector_t v);
        check_operator("operator", operator, v.operator);
        check_category("category", category, v.category);
        check_word("operand_a", operand_a, v.operand_a);
        check_word("operand_b", operand_b, v.operand_b);
        check_bit("wr_en", wr_en, v.wr_en);
        if (v.wr_en) begin
            check_reg_addr("wr_addr", wr_addr, v.wr_addr);
        end
        check_word("wr_data", wr_data, v.wr_data);
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        instruction = idle_instruction;
        pc          = 32'h0;
        ex_wr_en    = 1'b0;
        ex_wr_addr  = 5'd0;
        ex_wr_data  = 32'h0;
        mem_wr_en   = 1'b0;
        mem_wr_addr = 5'd0;
        mem_wr_data = 32'h0;

        repeat (5) @(posedge clk);
        #1;
        check_reset_state();
        arst_n = 1'b1;
        // released but no edge seen yet
        #2;
        check_reset_state();
        @(posedge clk);
        #1;

        for (int i = 0; i < num_vectors; i++) begin
            current = i;
            drive_vector(vectors[i]);
            #2;
            check_combinational(vectors[i]);
            @(posedge clk);
            #1;
            check_registered(vectors[i]);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+bench
logic/id_pkg.sv
logic/instruction_decoder.sv
logic/operand_select.sv
logic/branch_unit.sv
logic/id_ex_register.sv
logic/stage_id.sv
bench/stage_id_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the stage_id testbench with verilator, run it, then search the log

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

if ! verilator --binary --timing --top-module stage_id_tb --Mdir "$obj" \
        -o stage_id_sim -f filelist.f; then
    echo "verilator build failed"
    exit 1
fi

"./$obj/stage_id_sim" > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
